// File: source/nc32_decode_pkg.sv
// Widths, opcode encodings and packed packet types shared by the decode stage modules
`default_nettype none

package nc32_decode_pkg;

   localparam int WORD_W    = 32;
   localparam int PC_W      = WORD_W - 2;
   localparam int REG_AW    = 5;
   localparam int REG_COUNT = 32;
   localparam int OPC_W     = 6;
   localparam int IMM14_W   = 14;
   localparam int IMM18_W   = 18;
   localparam int LU_W      = 6;
   localparam int AU_W      = 4;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [PC_W-1:0]   pc_t;
   typedef logic [REG_AW-1:0] reg_addr_t;
   typedef logic [LU_W-1:0]   lu_opc_t;
   typedef logic [AU_W-1:0]   au_opc_t;

   // Bit positions in the logic unit one-hot
   localparam int LU_AND = 0;
   localparam int LU_OR  = 1;
   localparam int LU_XOR = 2;
   localparam int LU_LSL = 3;
   localparam int LU_LSR = 4;
   localparam int LU_ASR = 5;

   // Bit positions in the arithmetic unit one-hot
   localparam int AU_CMP = 0;
   localparam int AU_ADD = 1;
   localparam int AU_SUB = 2;
   localparam int AU_MHI = 3;

   // Natively decoded opcodes, anything else goes to emulation
   typedef enum logic [OPC_W-1:0] {
      OP_AND   = 6'h01,
      OP_AND_I = 6'h02,
      OP_OR    = 6'h03,
      OP_OR_I  = 6'h04,
      OP_XOR   = 6'h05,
      OP_XOR_I = 6'h06,
      OP_LSL   = 6'h07,
      OP_LSL_I = 6'h08,
      OP_LSR   = 6'h09,
      OP_LSR_I = 6'h0a,
      OP_ASR   = 6'h0b,
      OP_ASR_I = 6'h0c,
      OP_CMP   = 6'h0d,
      OP_ADD   = 6'h0e,
      OP_ADD_I = 6'h0f,
      OP_SUB   = 6'h10,
      OP_MHI   = 6'h11,
      OP_LDWU  = 6'h12,
      OP_STW   = 6'h13,
      OP_LDB   = 6'h14,
      OP_LDBU  = 6'h15,
      OP_LDH   = 6'h16,
      OP_LDHU  = 6'h17,
      OP_STB   = 6'h18,
      OP_STH   = 6'h19,
      OP_JMP   = 6'h1a,
      OP_MBARR = 6'h1b
   } opcode_e;

   // Memory access size
   typedef enum logic [2:0] {
      NONE = 3'd0,
      BYTE = 3'd1,
      HALF = 3'd2,
      WORD = 3'd3
   } mem_size_e;

   // Control packet handed to execute
   typedef struct packed {
      lu_opc_t   lu_opc;
      au_opc_t   au_opc;
      logic      emu;
      logic      mu_load;
      logic      mu_store;
      logic      mu_barr;
      mem_size_e load_size;
      mem_size_e store_size;
      logic      wb_regf;
      reg_addr_t wb_reg_addr;
      logic      jmp_reg;
      logic      jmp_link;
      pc_t       insn_pc;
   } exec_op_t;

   // Immediate and operand routing state kept next to the packet
   typedef struct packed {
      logic               sel14;
      logic               signed14;
      logic [IMM14_W-1:0] imm14;
      logic [IMM18_W-1:0] imm18;
      logic               rs2_is_reg;
      logic               is_store;
   } imm_ctl_t;

endpackage

`default_nettype wire

// File: source/nc32_pipebuf.sv
// One-entry valid/ready pipeline register, used between decode input and the execute port
`timescale 1ns/100ps
`default_nettype none

module nc32_pipebuf #(
   parameter int WIDTH = 1
) (
   input  wire logic             clk_i,
   input  wire logic             arst_n_i,
   input  wire logic             in_valid_i,
   output logic                  in_ready_o,
   input  wire logic [WIDTH-1:0] in_data_i,
   output logic                  out_valid_o,
   input  wire logic             out_ready_i,
   output logic [WIDTH-1:0]      out_data_o,
   output logic                  cas_o
);

   // Accept whenever the slot is free or drains this cycle
   assign in_ready_o = ~out_valid_o | out_ready_i;
   assign cas_o      = in_valid_i & in_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_valid_o <= 1'b0;
      end else if (cas_o) begin
         out_valid_o <= 1'b1;
      end else if (out_ready_i) begin
         out_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cas_o) begin
         out_data_o <= in_data_i;
      end
   end

endmodule

`default_nettype wire

// File: source/nc32_regfile.sv
// General purpose register file with two registered read ports and a single write port
`timescale 1ns/100ps
`default_nettype none

module nc32_regfile
   import nc32_decode_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      arst_n_i,
   input  wire logic      rs1_re_i,
   input  wire reg_addr_t rs1_addr_i,
   output word_t          rs1_data_o,
   output logic           rs1_valid_o,
   input  wire logic      rs2_re_i,
   input  wire reg_addr_t rs2_addr_i,
   output word_t          rs2_data_o,
   output logic           rs2_valid_o,
   input  wire logic      we_i,
   input  wire reg_addr_t waddr_i,
   input  wire word_t     wdata_i
);

   word_t regs [REG_COUNT];

   // r0 is hardwired, so it is never stored
   always_ff @(posedge clk_i) begin
      if (we_i && (waddr_i != '0)) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rs1_re_i) begin
         rs1_data_o <= (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
      end
      if (rs2_re_i) begin
         rs2_data_o <= (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
      end
   end

   // Flags follow the latest read request, a port left out of it goes invalid
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rs1_valid_o <= 1'b0;
         rs2_valid_o <= 1'b0;
      end else if (rs1_re_i | rs2_re_i) begin
         rs1_valid_o <= rs1_re_i;
         rs2_valid_o <= rs2_re_i;
      end
   end

endmodule

`default_nettype wire

// File: source/nc32_idu.sv
// Instruction decoder that classifies opcodes, requests operands and registers the execute packet
`timescale 1ns/100ps
`default_nettype none

module nc32_idu
   import nc32_decode_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      arst_n_i,
   input  wire logic      in_valid_i,
   output logic           in_ready_o,
   input  wire word_t     insn_i,
   input  wire pc_t       insn_pc_i,
   output logic           rs1_re_o,
   output reg_addr_t      rs1_addr_o,
   input  wire word_t     rs1_data_i,
   input  wire logic      rs1_valid_i,
   output logic           rs2_re_o,
   output reg_addr_t      rs2_addr_o,
   input  wire word_t     rs2_data_i,
   input  wire logic      rs2_valid_i,
   output logic           out_valid_o,
   input  wire logic      out_ready_i,
   output exec_op_t       exec_op_o,
   output word_t          opnd1_o,
   output word_t          opnd2_o,
   output word_t          opnd3_o,
   output logic           jmp_far_o,
   output pc_t            jmp_far_addr_o
);

   localparam int BUF_W = $bits(exec_op_t) + $bits(imm_ctl_t);

   opcode_e            f_opc;
   reg_addr_t          f_rd;
   reg_addr_t          f_rs1;
   reg_addr_t          f_rs2;
   logic [IMM14_W-1:0] f_imm14;
   logic [IMM18_W-1:0] f_imm18;

   logic op_and, op_and_i, op_or, op_or_i, op_xor, op_xor_i;
   logic op_lsl, op_lsl_i, op_lsr, op_lsr_i, op_asr, op_asr_i;
   logic op_cmp, op_add, op_add_i, op_sub, op_mhi, op_jmp, op_barr;
   logic op_ldb, op_ldbu, op_ldh, op_ldhu, op_ldwu, op_stb, op_sth, op_stw;
   logic op_load, op_store, op_emu, insn_rr, cas;

   lu_opc_t   lu_opc;
   au_opc_t   au_opc;
   mem_size_e load_size;
   mem_size_e store_size;
   exec_op_t  dec_op;
   imm_ctl_t  dec_imm;
   exec_op_t  op_q;
   imm_ctl_t  imm_q;
   logic [BUF_W-1:0] buf_q;
   word_t     simm14;
   word_t     uimm14;
   word_t     uimm18;
   word_t     imm_oper;
   logic      rs1_hit;

   // Register fields carry a sixth bit that this core ignores
   assign f_opc   = opcode_e'(insn_i[5:0]);
   assign f_rd    = insn_i[10:6];
   assign f_rs1   = insn_i[16:12];
   assign f_rs2   = insn_i[22:18];
   assign f_imm14 = insn_i[31:18];
   assign f_imm18 = insn_i[29:12];

   assign op_and   = (f_opc == OP_AND);
   assign op_and_i = (f_opc == OP_AND_I);
   assign op_or    = (f_opc == OP_OR);
   assign op_or_i  = (f_opc == OP_OR_I);
   assign op_xor   = (f_opc == OP_XOR);
   assign op_xor_i = (f_opc == OP_XOR_I);
   assign op_lsl   = (f_opc == OP_LSL);
   assign op_lsl_i = (f_opc == OP_LSL_I);
   assign op_lsr   = (f_opc == OP_LSR);
   assign op_lsr_i = (f_opc == OP_LSR_I);
   assign op_asr   = (f_opc == OP_ASR);
   assign op_asr_i = (f_opc == OP_ASR_I);
   assign op_cmp   = (f_opc == OP_CMP);
   assign op_add   = (f_opc == OP_ADD);
   assign op_add_i = (f_opc == OP_ADD_I);
   assign op_sub   = (f_opc == OP_SUB);
   assign op_mhi   = (f_opc == OP_MHI);
   assign op_jmp   = (f_opc == OP_JMP);
   assign op_barr  = (f_opc == OP_MBARR);
   assign op_ldb   = (f_opc == OP_LDB);
   assign op_ldbu  = (f_opc == OP_LDBU);
   assign op_ldh   = (f_opc == OP_LDH);
   assign op_ldhu  = (f_opc == OP_LDHU);
   assign op_ldwu  = (f_opc == OP_LDWU);
   assign op_stb   = (f_opc == OP_STB);
   assign op_sth   = (f_opc == OP_STH);
   assign op_stw   = (f_opc == OP_STW);

   assign lu_opc[LU_AND] = op_and | op_and_i;
   assign lu_opc[LU_OR]  = op_or | op_or_i;
   assign lu_opc[LU_XOR] = op_xor | op_xor_i;
   assign lu_opc[LU_LSL] = op_lsl | op_lsl_i;
   assign lu_opc[LU_LSR] = op_lsr | op_lsr_i;
   assign lu_opc[LU_ASR] = op_asr | op_asr_i;

   assign au_opc[AU_CMP] = op_cmp;
   assign au_opc[AU_ADD] = op_add | op_add_i;
   assign au_opc[AU_SUB] = op_sub;
   assign au_opc[AU_MHI] = op_mhi;

   assign load_size  = (op_ldb | op_ldbu) ? BYTE :
                       (op_ldh | op_ldhu) ? HALF :
                       op_ldwu            ? WORD : NONE;
   assign store_size = op_stb ? BYTE : op_sth ? HALF : op_stw ? WORD : NONE;
   assign op_load    = (load_size != NONE);
   assign op_store   = (store_size != NONE);

   // Nothing claimed it, so software emulates it
   assign op_emu  = ~((|lu_opc) | (|au_opc) | op_jmp | op_load | op_store | op_barr);
   assign insn_rr = op_and | op_or | op_xor | op_lsl | op_lsr | op_asr |
                    op_add | op_sub | op_cmp;

   always_comb begin
      dec_op.lu_opc      = lu_opc;
      dec_op.au_opc      = au_opc;
      dec_op.emu         = op_emu;
      dec_op.mu_load     = op_load;
      dec_op.mu_store    = op_store;
      dec_op.mu_barr     = op_barr;
      dec_op.load_size   = load_size;
      dec_op.store_size  = store_size;
      dec_op.wb_regf     = ~(op_cmp | op_barr | op_store | op_emu);
      dec_op.wb_reg_addr = f_rd;
      dec_op.jmp_reg     = op_jmp;
      dec_op.jmp_link    = op_jmp;
      dec_op.insn_pc     = insn_pc_i;
      dec_imm.sel14      = op_and_i | op_or_i | op_xor_i | op_lsl_i | op_lsr_i |
                           op_asr_i | op_add_i | op_load | op_store;
      dec_imm.signed14   = op_and_i | op_xor_i | op_add_i | op_load | op_store;
      dec_imm.imm14      = f_imm14;
      dec_imm.imm18      = f_imm18;
      dec_imm.rs2_is_reg = insn_rr;
      dec_imm.is_store   = op_store;
   end

   // Reads launch with the capture so data lines up with the buffered packet
   assign rs1_re_o   = cas & ~(op_barr | op_emu);
   assign rs1_addr_o = f_rs1;
   // A store sends its data register, named by rd, through port 2
   assign rs2_re_o   = cas & (insn_rr | op_store);
   assign rs2_addr_o = op_store ? f_rd : f_rs2;

   nc32_pipebuf #(
      .WIDTH (BUF_W)
   ) u_pipebuf (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .in_data_i   ({dec_op, dec_imm}),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_data_o  (buf_q),
      .cas_o       (cas)
   );

   assign {op_q, imm_q} = buf_q;
   assign exec_op_o     = op_q;

   assign simm14   = {{(WORD_W-IMM14_W){imm_q.imm14[IMM14_W-1]}}, imm_q.imm14};
   assign uimm14   = {{(WORD_W-IMM14_W){1'b0}}, imm_q.imm14};
   assign uimm18   = {{(WORD_W-IMM18_W){1'b0}}, imm_q.imm18};
   assign imm_oper = imm_q.sel14 ? (imm_q.signed14 ? simm14 : uimm14) : uimm18;

   // The regfile flag can be stale after mbarr or an emulated opcode, which read nothing
   assign rs1_hit = rs1_valid_i & ~(op_q.mu_barr | op_q.emu);

   assign opnd1_o = rs1_hit ? rs1_data_i : imm_oper;
   assign opnd2_o = (rs2_valid_i & imm_q.rs2_is_reg) ? rs2_data_i : imm_oper;
   assign opnd3_o = imm_q.is_store ? rs2_data_i : '0;

   assign jmp_far_o      = out_valid_o & op_q.jmp_reg;
   assign jmp_far_addr_o = rs1_data_i[WORD_W-1:2];

endmodule

`default_nettype wire

// File: source/nc32_decode_top.sv
// Decode stage top level joining the decoder to the register file and the pipeline ports
`timescale 1ns/100ps
`default_nettype none

module nc32_decode_top
   import nc32_decode_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      arst_n_i,
   // Fetch side
   input  wire logic      insn_valid_i,
   output logic           insn_ready_o,
   input  wire word_t     insn_i,
   input  wire pc_t       insn_pc_i,
   // Execute side
   output logic           exec_valid_o,
   input  wire logic      exec_ready_i,
   output exec_op_t       exec_op_o,
   output word_t          exec_opnd1_o,
   output word_t          exec_opnd2_o,
   output word_t          exec_opnd3_o,
   output logic           jmp_far_o,
   output pc_t            jmp_far_addr_o,
   // Register load port
   input  wire logic      rf_we_i,
   input  wire reg_addr_t rf_waddr_i,
   input  wire word_t     rf_wdata_i
);

   logic      rs1_re;
   reg_addr_t rs1_addr;
   word_t     rs1_data;
   logic      rs1_valid;
   logic      rs2_re;
   reg_addr_t rs2_addr;
   word_t     rs2_data;
   logic      rs2_valid;

   nc32_idu u_idu (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .in_valid_i     (insn_valid_i),
      .in_ready_o     (insn_ready_o),
      .insn_i         (insn_i),
      .insn_pc_i      (insn_pc_i),
      .rs1_re_o       (rs1_re),
      .rs1_addr_o     (rs1_addr),
      .rs1_data_i     (rs1_data),
      .rs1_valid_i    (rs1_valid),
      .rs2_re_o       (rs2_re),
      .rs2_addr_o     (rs2_addr),
      .rs2_data_i     (rs2_data),
      .rs2_valid_i    (rs2_valid),
      .out_valid_o    (exec_valid_o),
      .out_ready_i    (exec_ready_i),
      .exec_op_o      (exec_op_o),
      .opnd1_o        (exec_opnd1_o),
      .opnd2_o        (exec_opnd2_o),
      .opnd3_o        (exec_opnd3_o),
      .jmp_far_o      (jmp_far_o),
      .jmp_far_addr_o (jmp_far_addr_o)
   );

   nc32_regfile u_regfile (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .rs1_re_i    (rs1_re),
      .rs1_addr_i  (rs1_addr),
      .rs1_data_o  (rs1_data),
      .rs1_valid_o (rs1_valid),
      .rs2_re_i    (rs2_re),
      .rs2_addr_i  (rs2_addr),
      .rs2_data_o  (rs2_data),
      .rs2_valid_o (rs2_valid),
      .we_i        (rf_we_i),
      .waddr_i     (rf_waddr_i),
      .wdata_i     (rf_wdata_i)
   );

endmodule

`default_nettype wire

// File: dv/nc32_decode_tb.sv
// Self-checking testbench for the decode stage, run as the simulation top with random stimulus
`timescale 1ns/100ps
`default_nettype none

module nc32_decode_tb
   import nc32_decode_pkg::*;
;

   localparam int          NUM_INSN   = 400;
   localparam int          WAIT_LIMIT = 64;
   localparam logic [31:0] SEED       = 32'he5fc_c0fd;

   // Expected view of one execute transfer
   typedef struct packed {
      exec_op_t op;
      word_t    opnd1;
      word_t    opnd2;
      word_t    opnd3;
      logic     jmp_far;
      pc_t      jmp_addr;
   } exp_t;

   logic      clk;
   logic      arst_n;
   logic      insn_valid;
   logic      insn_ready;
   word_t     insn;
   pc_t       insn_pc;
   logic      exec_valid;
   logic      exec_ready;
   exec_op_t  exec_op;
   word_t     exec_opnd1;
   word_t     exec_opnd2;
   word_t     exec_opnd3;
   logic      jmp_far;
   pc_t       jmp_far_addr;
   logic      rf_we;
   reg_addr_t rf_waddr;
   word_t     rf_wdata;

   logic [31:0] rand_state;
   word_t       mirror [REG_COUNT];
   exp_t        exp_q [$];
   exp_t        held;
   logic        stalled;

   nc32_decode_top dut_i (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .insn_valid_i   (insn_valid),
      .insn_ready_o   (insn_ready),
      .insn_i         (insn),
      .insn_pc_i      (insn_pc),
      .exec_valid_o   (exec_valid),
      .exec_ready_i   (exec_ready),
      .exec_op_o      (exec_op),
      .exec_opnd1_o   (exec_opnd1),
      .exec_opnd2_o   (exec_opnd2),
      .exec_opnd3_o   (exec_opnd3),
      .jmp_far_o      (jmp_far),
      .jmp_far_addr_o (jmp_far_addr),
      .rf_we_i        (rf_we),
      .rf_waddr_i     (rf_waddr),
      .rf_wdata_i     (rf_wdata)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check(input logic [255:0] got, input logic [255:0] want, input string what);
      if (got !== want) begin
         abort_run($sformatf("Mismatch at %0t: %s, got 0x%0h expected 0x%0h",
                             $time, what, got, want));
      end
   endtask

   // Mostly kept opcodes with roughly one in ten from the emulated range or zero
   function automatic word_t gen_insn();
      logic [31:0] hi;
      logic [31:0] lo;
      logic [5:0]  opc;
      int          pick;
      hi   = lcg_next();
      lo   = lcg_next();
      pick = int'(lcg_next() >> 16);
      if (pick % 10 == 0) begin
         opc = 6'(((pick / 10) % 37 + 28) % 64);
      end else begin
         opc = 6'(1 + (pick / 10) % 27);
      end
      return {hi[31:16], lo[31:22], opc};
   endfunction

   // Reference decode built from the field layout and operand rules
   function automatic exp_t model_decode(input word_t w, input pc_t pc);
      exp_t      e;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     s14;
      word_t     u14;
      word_t     imm;
      logic      rr;
      logic      st;
      logic      rd1;
      logic      wb;
      rd  = w[10:6];
      rs1 = w[16:12];
      rs2 = w[22:18];
      s14 = {{18{w[31]}}, w[31:18]};
      u14 = {18'd0, w[31:18]};
      imm = {14'd0, w[29:12]};
      rr  = 1'b0;
      e   = '0;
      e.op.load_size  = NONE;
      e.op.store_size = NONE;
      // Unit and memory classification
      case (w[5:0])
         OP_AND, OP_AND_I: e.op.lu_opc[LU_AND] = 1'b1;
         OP_OR, OP_OR_I:   e.op.lu_opc[LU_OR] = 1'b1;
         OP_XOR, OP_XOR_I: e.op.lu_opc[LU_XOR] = 1'b1;
         OP_LSL, OP_LSL_I: e.op.lu_opc[LU_LSL] = 1'b1;
         OP_LSR, OP_LSR_I: e.op.lu_opc[LU_LSR] = 1'b1;
         OP_ASR, OP_ASR_I: e.op.lu_opc[LU_ASR] = 1'b1;
         OP_CMP:           e.op.au_opc[AU_CMP] = 1'b1;
         OP_ADD, OP_ADD_I: e.op.au_opc[AU_ADD] = 1'b1;
         OP_SUB:           e.op.au_opc[AU_SUB] = 1'b1;
         OP_MHI:           e.op.au_opc[AU_MHI] = 1'b1;
         OP_LDB, OP_LDBU:  e.op.load_size = BYTE;
         OP_LDH, OP_LDHU:  e.op.load_size = HALF;
         OP_LDWU:          e.op.load_size = WORD;
         OP_STB:           e.op.store_size = BYTE;
         OP_STH:           e.op.store_size = HALF;
         OP_STW:           e.op.store_size = WORD;
         OP_JMP:           e.op.jmp_reg = 1'b1;
         OP_MBARR:         e.op.mu_barr = 1'b1;
         default:          e.op.emu = 1'b1;
      endcase
      // Second operand source and immediate form
      case (w[5:0])
         OP_AND, OP_OR, OP_XOR, OP_LSL, OP_LSR, OP_ASR,
         OP_CMP, OP_ADD, OP_SUB:
            rr = 1'b1;
         OP_AND_I, OP_XOR_I, OP_ADD_I, OP_LDB, OP_LDBU, OP_LDH, OP_LDHU,
         OP_LDWU, OP_STB, OP_STH, OP_STW:
            imm = s14;
         OP_OR_I, OP_LSL_I, OP_LSR_I, OP_ASR_I:
            imm = u14;
         default:
            rr = 1'b0;
      endcase
      st  = (e.op.store_size != NONE);
      rd1 = ~(e.op.mu_barr | e.op.emu);
      wb  = ~(e.op.au_opc[AU_CMP] | e.op.mu_barr | e.op.emu);
      e.op.mu_load     = (e.op.load_size != NONE);
      e.op.mu_store    = st;
      e.op.wb_regf     = wb & ~st;
      e.op.wb_reg_addr = rd;
      e.op.jmp_link    = e.op.jmp_reg;
      e.op.insn_pc     = pc;
      e.opnd1          = rd1 ? mirror[rs1] : imm;
      e.opnd2          = rr ? mirror[rs2] : imm;
      // Store data comes from the register named by rd
      e.opnd3          = st ? mirror[rd] : '0;
      e.jmp_far        = e.op.jmp_reg;
      e.jmp_addr       = mirror[rs1][31:2];
      return e;
   endfunction

   function automatic exp_t dut_outputs();
      exp_t o;
      o.op       = exec_op;
      o.opnd1    = exec_opnd1;
      o.opnd2    = exec_opnd2;
      o.opnd3    = exec_opnd3;
      o.jmp_far  = jmp_far;
      o.jmp_addr = jmp_far_addr;
      return o;
   endfunction

   task automatic compare_packet(input exp_t got, input exp_t want);
      check(256'(got.op), 256'(want.op), "execute packet");
      check(256'(got.opnd1), 256'(want.opnd1), "operand 1");
      check(256'(got.opnd2), 256'(want.opnd2), "operand 2");
      check(256'(got.opnd3), 256'(want.opnd3), "operand 3");
      check(256'(got.jmp_far), 256'(want.jmp_far), "jmp_far_o");
      if (want.jmp_far) begin
         check(256'(got.jmp_addr), 256'(want.jmp_addr), "jmp_far_addr_o");
      end
   endtask

   // Drive one clock on the falling edge and check what the next rising edge will see
   task automatic step(input logic v, input word_t w, input pc_t pc, output logic accepted);
      exp_t cur;
      exp_t want;
      @(negedge clk);
      insn_valid = v;
      insn       = w;
      insn_pc    = pc;
      exec_ready = ((lcg_next() >> 16) % 10) >= 3;
      #1;
      check(256'(exec_valid), 256'(exp_q.size() != 0), "exec_valid_o");
      check(256'(insn_ready), 256'((exp_q.size() == 0) || exec_ready), "insn_ready_o");
      if (!exec_valid) begin
         check(256'(jmp_far), 256'(0), "jmp_far_o while idle");
      end
      cur = dut_outputs();
      if (stalled) begin
         check(256'(cur), 256'(held), "outputs held during stall");
      end
      if (exec_valid && exec_ready) begin
         want = exp_q.pop_front();
         compare_packet(cur, want);
      end
      stalled  = exec_valid & ~exec_ready;
      held     = cur;
      accepted = insn_valid & insn_ready;
      if (accepted) begin
         exp_q.push_back(model_decode(insn, insn_pc));
      end
   endtask

   task automatic load_registers();
      for (int r = 0; r < REG_COUNT; r++) begin
         @(negedge clk);
         rf_we     = 1'b1;
         rf_waddr  = reg_addr_t'(r);
         rf_wdata  = lcg_next();
         mirror[r] = (r == 0) ? '0 : rf_wdata;
      end
      @(negedge clk);
      rf_we = 1'b0;
   endtask

   task automatic issue_insn(input word_t w, input pc_t pc);
      logic [31:0] r;
      int          gap;
      int          waited;
      logic        acc;
      r   = lcg_next() >> 16;
      gap = (r % 4 == 0) ? int'(r % 3) + 1 : 0;
      repeat (gap) step(1'b0, '0, '0, acc);
      waited = 0;
      acc    = 1'b0;
      while (!acc) begin
         if (waited == WAIT_LIMIT) begin
            abort_run("Timed out waiting for the decoder to accept an instruction");
         end else begin
            step(1'b1, w, pc, acc);
            waited++;
         end
      end
   endtask

   initial begin
      int   waited;
      logic acc;
      pc_t  pc;
      clk        = 1'b0;
      arst_n     = 1'b0;
      insn_valid = 1'b0;
      insn       = '0;
      insn_pc    = '0;
      exec_ready = 1'b0;
      rf_we      = 1'b0;
      rf_waddr   = '0;
      rf_wdata   = '0;
      rand_state = SEED;
      stalled    = 1'b0;
      held       = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      #1;
      check(256'(exec_valid), 256'(0), "exec_valid_o after reset");
      check(256'(jmp_far), 256'(0), "jmp_far_o after reset");
      check(256'(insn_ready), 256'(1), "insn_ready_o after reset");
      load_registers();
      pc = pc_t'(lcg_next());
      for (int i = 0; i < NUM_INSN; i++) begin
         issue_insn(gen_insn(), pc);
         pc = pc + pc_t'(1);
      end
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == WAIT_LIMIT) begin
            abort_run("Timed out waiting for the execute side to drain");
         end else begin
            step(1'b0, '0, '0, acc);
            waited++;
         end
      end
      // One more idle cycle catches a packet the model never expected
      step(1'b0, '0, '0, acc);
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: nc32_decode.f
source/nc32_decode_pkg.sv
source/nc32_pipebuf.sv
source/nc32_regfile.sv
source/nc32_idu.sv
source/nc32_decode_top.sv
dv/nc32_decode_tb.sv

// File: Makefile
# Verilator build and run for the nc32_decode testbench

VERILATOR ?= verilator
TOP       ?= nc32_decode_tb
FILELIST  ?= nc32_decode.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
